//--- common/ob_pkg.sv
`default_nettype none

package ob_pkg;

  // Field widths
  localparam int UID_W   = 8;
  localparam int PRICE_W = 10;
  localparam int QTY_W   = 10;

  typedef logic [UID_W-1:0]   uid_t;
  typedef logic [PRICE_W-1:0] price_t;
  typedef logic [QTY_W-1:0]   quantity_t;

  // Command opcodes
  typedef enum logic [2:0] {
    Op_Nop       = 3'd0,
    Op_QryBidAsk = 3'd1,
    Op_Buy       = 3'd2,
    Op_Sell      = 3'd3,
    Op_PopTopBid = 3'd4,
    Op_PopTopAsk = 3'd5
  } opcode_e;

  // Response status codes
  typedef enum logic [2:0] {
    S_Okay   = 3'd0,
    S_Bad    = 3'd1,
    S_BadPop = 3'd2,
    S_Reject = 3'd3
  } status_e;

  // Ingress command
  typedef struct packed {
    opcode_e   opcode;
    uid_t      uid;
    price_t    price;
    quantity_t quantity;
  } cmd_t;

  // One resting order in a book side
  typedef struct packed {
    uid_t      uid;
    price_t    price;
    quantity_t quantity;
  } entry_t;

  // Egress response, unused fields stay zero
  typedef struct packed {
    uid_t      uid;
    status_e   status;
    uid_t      bid_uid;
    uid_t      ask_uid;
    price_t    bid_price;
    price_t    ask_price;
    quantity_t quantity;
  } rsp_t;

  // Registered trade decision from the compare stage
  typedef struct packed {
    logic      vld;
    uid_t      bid_uid;
    uid_t      ask_uid;
    logic      bid_consumed;
    logic      ask_consumed;
    // Shares traded
    quantity_t quantity;
    // Shares left on the surviving head
    quantity_t remainder;
  } cmp_result_t;

endpackage

`default_nettype wire

//--- src/ob_cmd_latch.sv
`timescale 1ns/1ps
`default_nettype none

module ob_cmd_latch import ob_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic cmd_vld,
  input  cmd_t cmd,
  output logic cmd_pop,
  input  logic cmd_consume,
  output logic cmd_latch_vld,
  output cmd_t cmd_latch
);

  logic cmd_fetch;

  // Fetch when empty, or when the held command leaves this cycle
  assign cmd_fetch = cmd_vld & (cmd_consume | ~cmd_latch_vld);

  // Ingress side sees the fetch as its pop
  assign cmd_pop = cmd_fetch;

  // Fetch wins over consume, otherwise retain
  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_latch_vld <= 1'b0;
    end else if (cmd_fetch) begin
      cmd_latch_vld <= 1'b1;
    end else if (cmd_consume) begin
      cmd_latch_vld <= 1'b0;
    end
  end

  // Payload only
  always_ff @(posedge clk) begin
    if (cmd_fetch) begin
      cmd_latch <= cmd;
    end
  end

endmodule

`default_nettype wire

//--- book/ob_book_side.sv
`timescale 1ns/1ps
`default_nettype none

module ob_book_side import ob_pkg::*; #(
  parameter int BOOK_DEPTH = 4,
  parameter bit IS_BID     = 1'b0
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      insert,
  input  entry_t    insert_entry,
  input  logic      pop,
  input  logic      update_vld,
  input  quantity_t update_qty,
  output logic      head_vld,
  output entry_t    head,
  output logic      full
);

  entry_t                entries_q [BOOK_DEPTH];
  entry_t                entries_d [BOOK_DEPTH];
  logic [BOOK_DEPTH-1:0] vld_q;
  logic [BOOK_DEPTH-1:0] vld_d;

  // Slot holds an order that ranks behind the incoming one
  logic [BOOK_DEPTH-1:0] worse;

  always_comb begin
    for (int i = 0; i < BOOK_DEPTH; i++) begin
      // Strict compare keeps equal prices in arrival order
      if (IS_BID) begin
        worse[i] = ~vld_q[i] | (entries_q[i].price < insert_entry.price);
      end else begin
        worse[i] = ~vld_q[i] | (entries_q[i].price > insert_entry.price);
      end
    end
  end

  always_comb begin
    entries_d = entries_q;
    vld_d     = vld_q;

    if (insert) begin
      // Head slot takes the new order if it ranks first
      if (worse[0]) begin
        entries_d[0] = insert_entry;
        vld_d[0]     = 1'b1;
      end
      for (int i = 1; i < BOOK_DEPTH; i++) begin
        if (worse[i]) begin
          if (worse[i-1]) begin
            // Shift a worse order down by one
            entries_d[i] = entries_q[i-1];
            vld_d[i]     = vld_q[i-1];
          end else begin
            // First worse slot, new order lands here
            entries_d[i] = insert_entry;
            vld_d[i]     = 1'b1;
          end
        end
      end
    end else if (pop) begin
      // Move every order up one slot
      for (int i = 0; i < BOOK_DEPTH - 1; i++) begin
        entries_d[i] = entries_q[i+1];
      end
      vld_d = {1'b0, vld_q[BOOK_DEPTH-1:1]};
    end else if (update_vld) begin
      // Partial fill leaves a smaller head
      entries_d[0].quantity = update_qty;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      vld_q <= vld_d;
    end
  end

  always_ff @(posedge clk) begin
    entries_q <= entries_d;
  end

  // Head and full straight from flops
  assign head_vld = vld_q[0];
  assign head     = entries_q[0];
  assign full     = vld_q[BOOK_DEPTH-1];

endmodule

`default_nettype wire

//--- src/ob_match.sv
`timescale 1ns/1ps
`default_nettype none

module ob_match import ob_pkg::*; (
  input  logic        clk,
  input  logic        cmp_en,
  input  logic        bid_vld,
  input  entry_t      bid,
  input  logic        ask_vld,
  input  entry_t      ask,
  output cmp_result_t cmp_result
);

  // One extra bit carries the sign of the difference
  logic signed [QTY_W:0] ask_excess;
  logic signed [QTY_W:0] bid_excess;
  logic                  can_trade;
  cmp_result_t           cmp_d;

  always_comb begin
    // Crossed book with both heads present
    can_trade  = bid_vld & ask_vld & (bid.price >= ask.price);

    // Shares left on each side if the other fills fully
    ask_excess = $signed({1'b0, ask.quantity}) - $signed({1'b0, bid.quantity});
    bid_excess = $signed({1'b0, bid.quantity}) - $signed({1'b0, ask.quantity});

    cmp_d         = '0;
    cmp_d.bid_uid = bid.uid;
    cmp_d.ask_uid = ask.uid;

    if (can_trade) begin
      cmp_d.vld = 1'b1;
      if (ask_excess > 0) begin
        // Bid fills, ask keeps the excess
        cmp_d.bid_consumed = 1'b1;
        cmp_d.quantity     = bid.quantity;
        cmp_d.remainder    = quantity_t'(ask_excess);
      end else if (bid_excess > 0) begin
        // Ask fills, bid keeps the excess
        cmp_d.ask_consumed = 1'b1;
        cmp_d.quantity     = ask.quantity;
        cmp_d.remainder    = quantity_t'(bid_excess);
      end else begin
        // Exact match clears both heads
        cmp_d.bid_consumed = 1'b1;
        cmp_d.ask_consumed = 1'b1;
        cmp_d.quantity     = bid.quantity;
      end
    end
  end

  // Decision held until the next compare
  always_ff @(posedge clk) begin
    if (cmp_en) begin
      cmp_result <= cmp_d;
    end
  end

endmodule

`default_nettype wire

//--- src/ob_cntrl.sv
`timescale 1ns/1ps
`default_nettype none

module ob_cntrl import ob_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        cmd_latch_vld,
  input  cmd_t        cmd_latch,
  output logic        cmd_consume,
  input  logic        rsp_full,
  output logic        rsp_vld,
  output rsp_t        rsp,
  input  logic        bid_head_vld,
  input  entry_t      bid_head,
  input  logic        bid_full,
  output logic        bid_insert,
  output entry_t      bid_insert_entry,
  output logic        bid_pop,
  output logic        bid_update_vld,
  output quantity_t   bid_update_qty,
  input  logic        ask_head_vld,
  input  entry_t      ask_head,
  input  logic        ask_full,
  output logic        ask_insert,
  output entry_t      ask_insert_entry,
  output logic        ask_pop,
  output logic        ask_update_vld,
  output quantity_t   ask_update_qty,
  input  cmp_result_t cmp_result,
  output logic        cmp_en
);

  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    ISSUE_QRY = 2'd1,
    EXECUTE   = 2'd2
  } state_e;

  state_e state_q;
  state_e state_d;
  entry_t new_entry;

  // Order from the latched command
  assign new_entry = '{uid: cmd_latch.uid, price: cmd_latch.price,
                       quantity: cmd_latch.quantity};

  always_comb begin
    state_d          = state_q;
    cmd_consume      = 1'b0;
    rsp_vld          = 1'b0;
    rsp              = '0;
    cmp_en           = 1'b0;
    bid_insert       = 1'b0;
    bid_insert_entry = new_entry;
    bid_pop          = 1'b0;
    bid_update_vld   = 1'b0;
    bid_update_qty   = cmp_result.remainder;
    ask_insert       = 1'b0;
    ask_insert_entry = new_entry;
    ask_pop          = 1'b0;
    ask_update_vld   = 1'b0;
    ask_update_qty   = cmp_result.remainder;

    case (state_q)
      IDLE: begin
        // Every IDLE command answers at once, so stall on a full egress
        if (cmd_latch_vld && !rsp_full) begin
          rsp_vld    = 1'b1;
          rsp.uid    = cmd_latch.uid;
          rsp.status = S_Okay;
          case (cmd_latch.opcode)
            Op_Nop: begin
              cmd_consume = 1'b1;
            end
            Op_QryBidAsk: begin
              cmd_consume = 1'b1;
              // Empty side reports zero price
              rsp.bid_price = bid_head_vld ? bid_head.price : '0;
              rsp.ask_price = ask_head_vld ? ask_head.price : '0;
              if (!(bid_head_vld && ask_head_vld)) begin
                rsp.status = S_Bad;
              end
            end
            Op_Buy: begin
              if (bid_full) begin
                // No room, book untouched
                cmd_consume = 1'b1;
                rsp.status  = S_Reject;
              end else begin
                bid_insert = 1'b1;
                state_d    = ISSUE_QRY;
              end
            end
            Op_Sell: begin
              if (ask_full) begin
                cmd_consume = 1'b1;
                rsp.status  = S_Reject;
              end else begin
                ask_insert = 1'b1;
                state_d    = ISSUE_QRY;
              end
            end
            Op_PopTopBid: begin
              cmd_consume = 1'b1;
              bid_pop     = bid_head_vld;
              if (bid_head_vld) begin
                rsp.bid_uid   = bid_head.uid;
                rsp.bid_price = bid_head.price;
                rsp.quantity  = bid_head.quantity;
              end else begin
                rsp.status = S_BadPop;
              end
            end
            Op_PopTopAsk: begin
              cmd_consume = 1'b1;
              ask_pop     = ask_head_vld;
              if (ask_head_vld) begin
                rsp.ask_uid   = ask_head.uid;
                rsp.ask_price = ask_head.price;
                rsp.quantity  = ask_head.quantity;
              end else begin
                rsp.status = S_BadPop;
              end
            end
            default: begin
              // Unknown opcode, drop it with an error
              cmd_consume = 1'b1;
              rsp.status  = S_Bad;
            end
          endcase
        end
      end

      ISSUE_QRY: begin
        // Heads now reflect the last insert or trade
        cmp_en  = 1'b1;
        state_d = EXECUTE;
      end

      EXECUTE: begin
        if (cmp_result.vld) begin
          // Trade waits for egress room, result stays registered
          if (!rsp_full) begin
            bid_pop        = cmp_result.bid_consumed;
            ask_pop        = cmp_result.ask_consumed;
            // Surviving head keeps the remainder
            bid_update_vld = cmp_result.ask_consumed & ~cmp_result.bid_consumed;
            ask_update_vld = cmp_result.bid_consumed & ~cmp_result.ask_consumed;

            rsp_vld      = 1'b1;
            rsp.uid      = '1;
            rsp.status   = S_Okay;
            rsp.bid_uid  = cmp_result.bid_uid;
            rsp.ask_uid  = cmp_result.ask_uid;
            rsp.quantity = cmp_result.quantity;
            state_d      = ISSUE_QRY;
          end
        end else begin
          // Book no longer crossed, Buy or Sell done
          cmd_consume = 1'b1;
          state_d     = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

//--- src/ob_top.sv
`timescale 1ns/1ps
`default_nettype none

module ob_top import ob_pkg::*; #(
  parameter int BOOK_DEPTH = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic cmd_vld,
  input  cmd_t cmd,
  output logic cmd_pop,
  input  logic rsp_full,
  output logic rsp_vld,
  output rsp_t rsp
);

  // Latch to controller
  logic        cmd_latch_vld;
  cmd_t        cmd_latch;
  logic        cmd_consume;

  // Bid side
  logic        bid_insert;
  entry_t      bid_insert_entry;
  logic        bid_pop;
  logic        bid_update_vld;
  quantity_t   bid_update_qty;
  logic        bid_head_vld;
  entry_t      bid_head;
  logic        bid_full;

  // Ask side
  logic        ask_insert;
  entry_t      ask_insert_entry;
  logic        ask_pop;
  logic        ask_update_vld;
  quantity_t   ask_update_qty;
  logic        ask_head_vld;
  entry_t      ask_head;
  logic        ask_full;

  // Compare stage
  logic        cmp_en;
  cmp_result_t cmp_result;

  ob_cmd_latch u_cmd_latch (
    .clk           (clk),
    .rst           (rst),
    .cmd_vld       (cmd_vld),
    .cmd           (cmd),
    .cmd_pop       (cmd_pop),
    .cmd_consume   (cmd_consume),
    .cmd_latch_vld (cmd_latch_vld),
    .cmd_latch     (cmd_latch)
  );

  // Highest price first
  ob_book_side #(
    .BOOK_DEPTH (BOOK_DEPTH),
    .IS_BID     (1'b1)
  ) u_bid_book (
    .clk          (clk),
    .rst          (rst),
    .insert       (bid_insert),
    .insert_entry (bid_insert_entry),
    .pop          (bid_pop),
    .update_vld   (bid_update_vld),
    .update_qty   (bid_update_qty),
    .head_vld     (bid_head_vld),
    .head         (bid_head),
    .full         (bid_full)
  );

  // Lowest price first
  ob_book_side #(
    .BOOK_DEPTH (BOOK_DEPTH)
  ) u_ask_book (
    .clk          (clk),
    .rst          (rst),
    .insert       (ask_insert),
    .insert_entry (ask_insert_entry),
    .pop          (ask_pop),
    .update_vld   (ask_update_vld),
    .update_qty   (ask_update_qty),
    .head_vld     (ask_head_vld),
    .head         (ask_head),
    .full         (ask_full)
  );

  ob_match u_match (
    .clk        (clk),
    .cmp_en     (cmp_en),
    .bid_vld    (bid_head_vld),
    .bid        (bid_head),
    .ask_vld    (ask_head_vld),
    .ask        (ask_head),
    .cmp_result (cmp_result)
  );

  ob_cntrl u_cntrl (
    .clk              (clk),
    .rst              (rst),
    .cmd_latch_vld    (cmd_latch_vld),
    .cmd_latch        (cmd_latch),
    .cmd_consume      (cmd_consume),
    .rsp_full         (rsp_full),
    .rsp_vld          (rsp_vld),
    .rsp              (rsp),
    .bid_head_vld     (bid_head_vld),
    .bid_head         (bid_head),
    .bid_full         (bid_full),
    .bid_insert       (bid_insert),
    .bid_insert_entry (bid_insert_entry),
    .bid_pop          (bid_pop),
    .bid_update_vld   (bid_update_vld),
    .bid_update_qty   (bid_update_qty),
    .ask_head_vld     (ask_head_vld),
    .ask_head         (ask_head),
    .ask_full         (ask_full),
    .ask_insert       (ask_insert),
    .ask_insert_entry (ask_insert_entry),
    .ask_pop          (ask_pop),
    .ask_update_vld   (ask_update_vld),
    .ask_update_qty   (ask_update_qty),
    .cmp_result       (cmp_result),
    .cmp_en           (cmp_en)
  );

endmodule

`default_nettype wire

//--- testbench/tb_ob.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ob import ob_pkg::*; ();

  // Cycles allowed for any single wait
  localparam int WAIT_LIMIT   = 200;
  // Quiet cycles watched after the last response
  localparam int DRAIN_CYCLES = 40;

  logic clk      = 1'b0;
  logic rst      = 1'b1;
  logic cmd_vld  = 1'b0;
  cmd_t cmd      = '0;
  logic cmd_pop;
  logic rsp_full = 1'b0;
  logic rsp_vld;
  rsp_t rsp;

  // Commands and expected responses in file order
  cmd_t cmd_list [$];
  rsp_t exp_list [$];
  // Command now offered on the ingress
  int   next_cmd = 0;

  ob_top #(
    .BOOK_DEPTH (4)
  ) u_ob_top (
    .clk      (clk),
    .rst      (rst),
    .cmd_vld  (cmd_vld),
    .cmd      (cmd),
    .cmd_pop  (cmd_pop),
    .rsp_full (rsp_full),
    .rsp_vld  (rsp_vld),
    .rsp      (rsp)
  );

  // 40 ns clock
  initial begin
    forever #20 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_field_error(input string name, input logic [31:0] expv,
                                    input logic [31:0] actv);
    abort_run($sformatf("error: time %0t: %s expected %0h actual %0h",
                        $time, name, expv, actv));
  endtask

  task automatic verify_status(input status_e expv, input status_e actv);
    if (actv !== expv) begin
      abort_run($sformatf("error: time %0t: rsp.status expected %s actual %s",
                          $time, expv.name(), actv.name()));
    end
  endtask

  // Field by field until the first mismatch
  task automatic compare_response(input rsp_t expv, input rsp_t actv);
    if (actv.uid !== expv.uid) begin
      report_field_error("rsp.uid", 32'(expv.uid), 32'(actv.uid));
    end
    verify_status(expv.status, actv.status);
    if (actv.bid_uid !== expv.bid_uid) begin
      report_field_error("rsp.bid_uid", 32'(expv.bid_uid), 32'(actv.bid_uid));
    end
    if (actv.ask_uid !== expv.ask_uid) begin
      report_field_error("rsp.ask_uid", 32'(expv.ask_uid), 32'(actv.ask_uid));
    end
    if (actv.bid_price !== expv.bid_price) begin
      report_field_error("rsp.bid_price", 32'(expv.bid_price), 32'(actv.bid_price));
    end
    if (actv.ask_price !== expv.ask_price) begin
      report_field_error("rsp.ask_price", 32'(expv.ask_price), 32'(actv.ask_price));
    end
    if (actv.quantity !== expv.quantity) begin
      report_field_error("rsp.quantity", 32'(expv.quantity), 32'(actv.quantity));
    end
  endtask

  // C lines become commands, R lines expected responses
  task automatic load_stimulus();
    string line;
    int    fd;
    int    n;
    int    f [7];
    cmd_t  c;
    rsp_t  r;
    fd = $fopen("testbench/ob_stim.txt", "r");
    if (fd == 0) begin
      abort_run("the stimulus file could not be opened");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2) begin
        continue;
      end
      if (line.getc(0) == "C") begin
        n = $sscanf(line.substr(1, line.len() - 1), "%d %d %d %d",
                    f[0], f[1], f[2], f[3]);
        if (n != 4) begin
          abort_run({"malformed command line: ", line});
        end
        c.opcode   = opcode_e'(f[0][2:0]);
        c.uid      = uid_t'(f[1]);
        c.price    = price_t'(f[2]);
        c.quantity = quantity_t'(f[3]);
        cmd_list.push_back(c);
      end else if (line.getc(0) == "R") begin
        n = $sscanf(line.substr(1, line.len() - 1), "%d %d %d %d %d %d %d",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
        if (n != 7) begin
          abort_run({"malformed response line: ", line});
        end
        r.uid       = uid_t'(f[0]);
        r.status    = status_e'(f[1][2:0]);
        r.bid_uid   = uid_t'(f[2]);
        r.ask_uid   = uid_t'(f[3]);
        r.bid_price = price_t'(f[4]);
        r.ask_price = price_t'(f[5]);
        r.quantity  = quantity_t'(f[6]);
        exp_list.push_back(r);
      end else if (line.getc(0) != "#") begin
        abort_run({"unknown line in the stimulus file: ", line});
      end
    end
    $fclose(fd);
    if (exp_list.size() == 0 || cmd_list.size() == 0) begin
      abort_run("the stimulus file holds no commands or no responses");
    end
  endtask

  // Ingress driver advances when the latch pops
  always @(posedge clk) begin
    if (rst) begin
      cmd_vld <= 1'b0;
    end else begin
      if (cmd_vld && cmd_pop) begin
        next_cmd = next_cmd + 1;
      end
      if (next_cmd < cmd_list.size()) begin
        cmd_vld <= 1'b1;
        cmd     <= cmd_list[next_cmd];
      end else begin
        cmd_vld <= 1'b0;
      end
    end
  end

  // Egress back-pressure about one cycle in four
  initial begin
    void'($urandom(32'hbd0));
    forever begin
      @(posedge clk);
      if (rst) begin
        rsp_full <= 1'b0;
      end else begin
        rsp_full <= (($urandom % 32'd4) == 32'd0);
      end
    end
  end

  // Monitor samples at negedge where rsp is settled
  initial begin
    int waited;
    load_stimulus();
    repeat (10) begin
      @(posedge clk);
    end
    rst <= 1'b0;

    foreach (exp_list[r]) begin
      waited = 0;
      @(negedge clk);
      while (!rsp_vld) begin
        waited++;
        if (waited > WAIT_LIMIT) begin
          abort_run($sformatf("no response arrived in time for expected response %0d", r));
        end
        @(negedge clk);
      end
      compare_response(exp_list[r], rsp);
    end

    // Nothing more may come out
    for (int k = 0; k < DRAIN_CYCLES; k++) begin
      @(negedge clk);
      if (rsp_vld) begin
        abort_run("an extra response appeared after the last expected one");
      end
    end

    if (next_cmd == cmd_list.size() && !cmd_vld) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      abort_run("not every command was taken by the DUT");
    end
  end

endmodule

`default_nettype wire

//--- testbench/ob_stim.txt
# C opcode uid price quantity (opcode 0 Nop 1 Qry 2 Buy 3 Sell 4 PopBid 5 PopAsk)
# R uid status bid_uid ask_uid bid_price ask_price quantity (status 0 Okay 1 Bad 2 BadPop 3 Reject)
# Empty book
C 0 1 0 0
R 1 0 0 0 0 0 0
C 1 2 0 0
R 2 1 0 0 0 0 0
C 4 3 0 0
R 3 2 0 0 0 0 0
C 5 4 0 0
R 4 2 0 0 0 0 0
# Resting orders, no cross
C 2 10 100 50
R 10 0 0 0 0 0 0
C 2 11 105 20
R 11 0 0 0 0 0 0
C 2 12 100 30
R 12 0 0 0 0 0 0
C 3 20 110 40
R 20 0 0 0 0 0 0
C 3 21 108 25
R 21 0 0 0 0 0 0
C 3 22 110 15
R 22 0 0 0 0 0 0
C 1 30 0 0
R 30 0 0 0 105 108 0
C 4 31 0 0
R 31 0 11 0 105 0 20
C 5 32 0 0
R 32 0 0 21 0 108 25
C 1 33 0 0
R 33 0 0 0 100 110 0
# Sell partial fill of the bid head
C 3 40 100 20
R 40 0 0 0 0 0 0
R 255 0 10 40 0 0 20
C 1 41 0 0
R 41 0 0 0 100 110 0
# Sell across two bid orders
C 3 42 95 70
R 42 0 0 0 0 0 0
R 255 0 10 42 0 0 30
R 255 0 12 42 0 0 30
C 1 43 0 0
R 43 1 0 0 0 95 0
# Exact fill
C 2 44 96 10
R 44 0 0 0 0 0 0
R 255 0 44 42 0 0 10
# Buy across two ask orders at one price
C 2 45 110 50
R 45 0 0 0 0 0 0
R 255 0 45 20 0 0 40
R 255 0 45 22 0 0 10
C 5 46 0 0
R 46 0 0 22 0 110 5
# Fill the bid side, fifth Buy rejected
C 2 50 90 10
R 50 0 0 0 0 0 0
C 2 51 92 11
R 51 0 0 0 0 0 0
C 2 52 88 12
R 52 0 0 0 0 0 0
C 2 53 92 13
R 53 0 0 0 0 0 0
C 2 54 99 14
R 54 3 0 0 0 0 0
C 3 55 200 5
R 55 0 0 0 0 0 0
C 4 56 0 0
R 56 0 51 0 92 0 11
C 4 57 0 0
R 57 0 53 0 92 0 13
C 4 58 0 0
R 58 0 50 0 90 0 10
C 4 59 0 0
R 59 0 52 0 88 0 12
C 4 60 0 0
R 60 2 0 0 0 0 0
C 5 61 0 0
R 61 0 0 55 0 200 5
C 0 62 0 0
R 62 0 0 0 0 0 0

//--- all.f
common/ob_pkg.sv
src/ob_cmd_latch.sv
book/ob_book_side.sv
src/ob_match.sv
src/ob_cntrl.sv
src/ob_top.sv
testbench/tb_ob.sv

//--- Makefile
SRCS := $(shell grep '\.sv$$' all.f)

.PHONY: run clean

run: obj_dir/Vtb_ob
	./obj_dir/Vtb_ob | tee sim.log
	grep -q "TEST PASSED" sim.log

obj_dir/Vtb_ob: all.f $(SRCS) testbench/ob_stim.txt
	verilator --binary --top-module tb_ob -f all.f

clean:
	rm -rf obj_dir sim.log
